// ==== hdl/lsu_macros.svh ====
//******************************
// LSU shared width and size macros
// DCCM window, store buffer depth
//******************************

`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// Datapath
`define LSU_XLEN        32            // Data and address width
`define LSU_OFFSET_W    12            // Signed immediate offset

// DCCM window
`define LSU_DCCM_BASE   32'hF004_0000 // First byte of DCCM
`define LSU_DCCM_DEPTH  256           // Words
`define LSU_DCCM_AW     8             // Word address bits

// Store buffer
`define LSU_STBUF_DEPTH 4             // Entries
`define LSU_STBUF_PTR_W 2             // Pointer bits, depth is a power of two

`endif

// ==== hdl/lsu_pkg.sv ====
//******************************
// LSU shared types
// Opcodes, sizes, request/response and stage payloads
//******************************

`default_nettype none

`include "lsu_macros.svh"

package lsu_pkg;

   typedef enum logic [0:0] {
      LSU_OP_LOAD  = 1'b0,
      LSU_OP_STORE = 1'b1
   } lsu_op_e;

   typedef enum logic [1:0] {
      LSU_SZ_BYTE = 2'd0,
      LSU_SZ_HALF = 2'd1,
      LSU_SZ_WORD = 2'd2
   } lsu_size_e;

   typedef enum logic [1:0] {
      LSU_ERR_NONE       = 2'd0,
      LSU_ERR_MISALIGNED = 2'd1,  // Half not 2-aligned or word not 4-aligned
      LSU_ERR_ACCESS     = 2'd2   // Outside DCCM window
   } lsu_err_e;

   // Host request
   typedef struct packed {
      lsu_op_e                   op;
      lsu_size_e                 size;
      logic                      is_unsigned;  // Zero extend loads
      logic [`LSU_XLEN-1:0]      base;
      logic [`LSU_OFFSET_W-1:0]  offset;       // Signed
      logic [`LSU_XLEN-1:0]      wdata;
   } lsu_req_t;

   // Response, one per request
   typedef struct packed {
      logic [`LSU_XLEN-1:0]      data;
      lsu_err_e                  err;
   } lsu_rsp_t;

   // Decoded access out of DC1
   typedef struct packed {
      lsu_op_e                   op;
      lsu_size_e                 size;
      logic                      is_unsigned;
      logic [1:0]                byte_off;     // Byte within word
      logic [`LSU_DCCM_AW-1:0]   word_addr;
      logic [3:0]                be;
      logic [`LSU_XLEN-1:0]      data;         // Store data in byte lanes
      lsu_err_e                  err;
   } lsu_dc1_t;

   // Store buffer forwarding result
   typedef struct packed {
      logic [3:0]                hit;          // Per byte
      logic [`LSU_XLEN-1:0]      data;
   } lsu_fwd_t;

endpackage

`default_nettype wire

// ==== hdl/lsu_addr_ctl.sv ====
//******************************
// LSU DC1 address control
// EA generation, DCCM decode, fault check
//******************************

`timescale 1ns/10ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_addr_ctl (
   input  lsu_pkg::lsu_req_t  req,
   output lsu_pkg::lsu_dc1_t  acc
);

   logic [`LSU_XLEN-1:0]  ea;          // Effective address
   logic [`LSU_XLEN-1:0]  rel;         // Offset from DCCM base
   logic [`LSU_XLEN-1:0]  offset_ext;
   logic                  in_dccm;
   logic                  misaligned;
   logic [3:0]            be_base;     // Mask before lane shift

   //******************************
   // Address generation
   //******************************
   assign offset_ext = {{(`LSU_XLEN-`LSU_OFFSET_W){req.offset[`LSU_OFFSET_W-1]}}, req.offset};
   assign ea         = req.base + offset_ext;

   // Below base wraps to a large value and fails the range check
   assign rel     = ea - `LSU_DCCM_BASE;
   assign in_dccm = (rel < (`LSU_DCCM_DEPTH * 4));

   //******************************
   // Size decode and alignment
   //******************************
   always_comb begin
      case (req.size)
         lsu_pkg::LSU_SZ_BYTE: begin
            misaligned = 1'b0;
            be_base    = 4'b0001;
         end
         lsu_pkg::LSU_SZ_HALF: begin
            misaligned = ea[0];          // Needs 2-alignment
            be_base    = 4'b0011;
         end
         default: begin
            misaligned = |ea[1:0];       // Word needs 4-alignment
            be_base    = 4'b1111;
         end
      endcase
   end

   //******************************
   // Decoded access
   //******************************
   always_comb begin
      acc.op          = req.op;
      acc.size        = req.size;
      acc.is_unsigned = req.is_unsigned;
      acc.byte_off    = ea[1:0];
      acc.word_addr   = rel[`LSU_DCCM_AW+1:2];
      acc.be          = be_base << ea[1:0];
      acc.data        = req.wdata << {ea[1:0], 3'b000};  // Move into byte lanes

      // Misalignment reported ahead of an access fault
      if (misaligned)
         acc.err = lsu_pkg::LSU_ERR_MISALIGNED;
      else if (!in_dccm)
         acc.err = lsu_pkg::LSU_ERR_ACCESS;
      else
         acc.err = lsu_pkg::LSU_ERR_NONE;
   end

endmodule

`default_nettype wire

// ==== hdl/lsu_stbuf.sv ====
//******************************
// LSU store buffer
// Circular FIFO of stores, byte forwarding to DC1 loads
// Head entry drains into the DCCM
//******************************

`timescale 1ns/10ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_stbuf (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          alloc,        // Store leaves DC1
   input  lsu_pkg::lsu_dc1_t             acc,
   input  logic                          drain_en,
   output logic                          drain_valid,
   output logic [`LSU_DCCM_AW-1:0]       drain_addr,
   output logic [`LSU_XLEN-1:0]          drain_data,
   output logic [3:0]                    drain_be,
   output lsu_pkg::lsu_fwd_t             fwd,
   output logic                          full,
   output logic                          empty
);

   // Entry storage
   logic [`LSU_DCCM_AW-1:0]       sb_addr [`LSU_STBUF_DEPTH];
   logic [3:0]                    sb_be   [`LSU_STBUF_DEPTH];
   logic [`LSU_XLEN-1:0]          sb_data [`LSU_STBUF_DEPTH];

   logic [`LSU_STBUF_PTR_W-1:0]   wr_ptr;
   logic [`LSU_STBUF_PTR_W-1:0]   rd_ptr;
   logic [`LSU_STBUF_PTR_W:0]     count;   // One extra bit to reach DEPTH

   //******************************
   // Status and head entry
   //******************************
   assign empty       = (count == '0);
   assign full        = (count == (`LSU_STBUF_PTR_W+1)'(`LSU_STBUF_DEPTH));
   assign drain_valid = !empty;
   assign drain_addr  = sb_addr[rd_ptr];
   assign drain_data  = sb_data[rd_ptr];
   assign drain_be    = sb_be[rd_ptr];

   //******************************
   // Pointers and occupancy
   //******************************
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (alloc)
            wr_ptr <= wr_ptr + 1'b1;
         if (drain_en)
            rd_ptr <= rd_ptr + 1'b1;

         case ({alloc, drain_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;        // Both or neither
         endcase
      end
   end

   // Payload write, no reset on entries
   always_ff @(posedge clk) begin
      if (alloc) begin
         sb_addr[wr_ptr] <= acc.word_addr;
         sb_be[wr_ptr]   <= acc.be;
         sb_data[wr_ptr] <= acc.data;
      end
   end

   //******************************
   // Forwarding
   //******************************
   // Walk from oldest to youngest so later matches overwrite earlier ones
   always_comb begin : fwd_search
      logic [`LSU_STBUF_PTR_W-1:0] idx;
      logic                        live;

      fwd = '0;
      for (int i = 0; i < `LSU_STBUF_DEPTH; i++) begin
         idx  = rd_ptr + `LSU_STBUF_PTR_W'(i);
         live = ((`LSU_STBUF_PTR_W+1)'(i) < count);   // Entry holds a store
         if (live && (sb_addr[idx] == acc.word_addr)) begin
            for (int b = 0; b < 4; b++) begin
               if (sb_be[idx][b]) begin
                  fwd.hit[b]         = 1'b1;
                  fwd.data[8*b +: 8] = sb_data[idx][8*b +: 8];
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== hdl/lsu_dccm_ram.sv ====
//******************************
// LSU data memory (DCCM)
// Single port, byte writes, registered read
//******************************

`timescale 1ns/10ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_dccm_ram (
   input  logic                       clk,
   input  logic                       rden,
   input  logic                       wren,
   input  logic [`LSU_DCCM_AW-1:0]    addr,     // Word address
   input  logic [`LSU_XLEN-1:0]       wr_data,
   input  logic [3:0]                 wr_be,
   output logic [`LSU_XLEN-1:0]       rd_data
);

   logic [`LSU_XLEN-1:0] mem [`LSU_DCCM_DEPTH];

   // Byte masked write
   always_ff @(posedge clk) begin
      if (wren) begin
         for (int b = 0; b < 4; b++) begin
            if (wr_be[b])
               mem[addr][8*b +: 8] <= wr_data[8*b +: 8];
         end
      end
   end

   // Read data holds while rden is low
   always_ff @(posedge clk) begin
      if (rden)
         rd_data <= mem[addr];
   end

endmodule

`default_nettype wire

// ==== hdl/lsu_load_align.sv ====
//******************************
// LSU DC2 load alignment
// Byte merge, shift and extension
//******************************

`timescale 1ns/10ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_load_align (
   input  lsu_pkg::lsu_dc1_t        acc,
   input  lsu_pkg::lsu_fwd_t        fwd,
   input  logic [`LSU_XLEN-1:0]     mem_data,
   output lsu_pkg::lsu_rsp_t        rsp
);

   logic [`LSU_XLEN-1:0] merged;    // Store buffer over memory
   logic [`LSU_XLEN-1:0] shifted;
   logic [`LSU_XLEN-1:0] ext;
   logic                 ld_ok;

   always_comb begin
      for (int b = 0; b < 4; b++)
         merged[8*b +: 8] = fwd.hit[b] ? fwd.data[8*b +: 8] : mem_data[8*b +: 8];
   end

   assign shifted = merged >> {acc.byte_off, 3'b000};  // Addressed byte to bit 0

   // Extension by size and the unsigned flag
   always_comb begin
      case (acc.size)
         lsu_pkg::LSU_SZ_BYTE:
            ext = acc.is_unsigned ? {24'b0, shifted[7:0]} :
                                    {{24{shifted[7]}}, shifted[7:0]};
         lsu_pkg::LSU_SZ_HALF:
            ext = acc.is_unsigned ? {16'b0, shifted[15:0]} :
                                    {{16{shifted[15]}}, shifted[15:0]};
         default:
            ext = shifted;
      endcase
   end

   // Only a good load returns data
   assign ld_ok    = (acc.op == lsu_pkg::LSU_OP_LOAD) && (acc.err == lsu_pkg::LSU_ERR_NONE);
   assign rsp.data = ld_ok ? ext : '0;
   assign rsp.err  = acc.err;

endmodule

`default_nettype wire

// ==== hdl/lsu_top.sv ====
//******************************
// LSU top level
// DC1 -> DC2 -> DC3 pipeline, store buffer, DCCM
//******************************

`timescale 1ns/10ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_top (
   input  logic               clk,
   input  logic               rst,
   input  logic               req_valid,
   output logic               req_ready,
   input  lsu_pkg::lsu_req_t  req,
   output logic               rsp_valid,
   input  logic               rsp_ready,
   output lsu_pkg::lsu_rsp_t  rsp,
   output logic               lsu_idle
);

   // Stage state
   logic                  dc1_valid, dc2_valid, dc3_valid;
   lsu_pkg::lsu_req_t     dc1_req;
   lsu_pkg::lsu_dc1_t     dc1_acc, dc2_acc;
   lsu_pkg::lsu_fwd_t     dc1_fwd, dc2_fwd;
   lsu_pkg::lsu_rsp_t     dc2_rsp, dc3_rsp;

   // Control
   logic                  advance, stall;
   logic                  dc1_ok, dc1_ld, dc1_st;

   // Store buffer and memory port
   logic                  sb_alloc, sb_drain_en, sb_drain_valid, sb_full, sb_empty;
   logic [`LSU_DCCM_AW-1:0] sb_drain_addr;
   logic [`LSU_XLEN-1:0]  sb_drain_data;
   logic [3:0]            sb_drain_be;
   logic                  mem_rden, mem_wren;
   logic [`LSU_DCCM_AW-1:0] mem_addr;
   logic [`LSU_XLEN-1:0]  mem_rd_data;

   //******************************
   // DC1 decode and stall
   //******************************
   lsu_addr_ctl addr_ctl_i (.req(dc1_req), .acc(dc1_acc));

   assign dc1_ok  = dc1_valid && (dc1_acc.err == lsu_pkg::LSU_ERR_NONE);  // Faults skip memory
   assign dc1_ld  = dc1_ok && (dc1_acc.op == lsu_pkg::LSU_OP_LOAD);
   assign dc1_st  = dc1_ok && (dc1_acc.op == lsu_pkg::LSU_OP_STORE);
   assign stall   = dc1_st && sb_full;                   // No room to allocate
   assign advance = (!dc3_valid || rsp_ready) && !stall;
   assign req_ready = advance;

   assign sb_alloc    = dc1_st && advance;
   assign sb_drain_en = sb_drain_valid && !dc1_ld;       // Load owns the port

   lsu_stbuf stbuf_i (
      .clk(clk), .rst(rst), .alloc(sb_alloc), .acc(dc1_acc),
      .drain_en(sb_drain_en), .drain_valid(sb_drain_valid), .drain_addr(sb_drain_addr),
      .drain_data(sb_drain_data), .drain_be(sb_drain_be), .fwd(dc1_fwd),
      .full(sb_full), .empty(sb_empty)
   );

   // Memory port, read held when stage holds
   assign mem_rden = dc1_ld && advance;
   assign mem_wren = sb_drain_en;
   assign mem_addr = dc1_ld ? dc1_acc.word_addr : sb_drain_addr;

   lsu_dccm_ram dccm_i (
      .clk(clk), .rden(mem_rden), .wren(mem_wren), .addr(mem_addr),
      .wr_data(sb_drain_data), .wr_be(sb_drain_be), .rd_data(mem_rd_data)
   );

   // DC2 alignment
   lsu_load_align align_i (.acc(dc2_acc), .fwd(dc2_fwd), .mem_data(mem_rd_data), .rsp(dc2_rsp));

   //******************************
   // Stage registers
   //******************************
   always_ff @(posedge clk) begin
      if (rst) begin
         dc1_valid <= 1'b0;
         dc2_valid <= 1'b0;
         dc3_valid <= 1'b0;
      end else if (advance) begin
         dc1_valid <= req_valid;
         dc2_valid <= dc1_valid;
         dc3_valid <= dc2_valid;
      end else if (rsp_ready) begin
         dc3_valid <= 1'b0;  // Response taken while DC1 stalls
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         dc1_req <= req;
         dc2_acc <= dc1_acc;
         dc2_fwd <= dc1_fwd;   // Forward result travels with the load
         dc3_rsp <= dc2_rsp;
      end
   end

   assign rsp_valid = dc3_valid;
   assign rsp       = dc3_rsp;
   assign lsu_idle  = !dc1_valid && !dc2_valid && !dc3_valid && sb_empty;

endmodule

`default_nettype wire

// ==== sim/lsu_properties.sv ====
//******************************
// LSU protocol assertions
// Response hold, ready, memory port use
//******************************

`timescale 1ns/10ps
`default_nettype none

module lsu_properties (
   input logic               clk,
   input logic               rst,
   input logic               req_ready,
   input logic               rsp_valid,
   input logic               rsp_ready,
   input lsu_pkg::lsu_rsp_t  rsp,
   input logic               dc1_valid,
   input logic               dc2_valid,
   input logic               dc3_valid,
   input logic               sb_full,
   input logic               mem_rden,
   input logic               mem_wren
);

   int unsigned fail_count = 0;   // Assertion failures so far

   // Response held until taken
   rsp_hold: assert property (@(posedge clk) disable iff (rst)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
      else begin
         fail_count++;
         $error("Response changed while rsp_ready was low");
      end

   // Empty pipe with room in the store buffer accepts
   ready_when_empty: assert property (@(posedge clk) disable iff (rst)
      (!dc1_valid && !dc2_valid && !dc3_valid && !sb_full) |-> req_ready)
      else begin
         fail_count++;
         $error("req_ready low with empty pipeline");
      end

   // One user of the single memory port
   port_exclusive: assert property (@(posedge clk) disable iff (rst)
      !(mem_rden && mem_wren))
      else begin
         fail_count++;
         $error("DCCM read and write in the same cycle");
      end

   rsp_after_reset: assert property (@(posedge clk) rst |=> !rsp_valid)
      else begin
         fail_count++;
         $error("rsp_valid high after reset");
      end

endmodule

`default_nettype wire

// ==== sim/lsu_tb.sv ====
//******************************
// LSU testbench
// Vector driven, byte reference model, random response stalls
//******************************

`timescale 1ns/10ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_tb;

   localparam int          CLK_PERIOD   = 4;              // ns
   localparam int          RESET_CYCLES = 10;
   localparam int          VEC_COUNT    = 28;
   localparam int          TIMEOUT_NS   = VEC_COUNT * 20 * CLK_PERIOD;
   localparam int          IDLE_CYCLES  = 20;
   localparam logic [31:0] SEED         = 32'd79919;
   localparam int          G1_END       = 5;              // First index past each group
   localparam int          G2_END       = 11;
   localparam int          G3_END       = 16;
   localparam int          G4_END       = 21;

   logic                clk = 1'b0;
   logic                rst = 1'b1;
   logic                req_valid = 1'b0;
   logic                req_ready;
   lsu_pkg::lsu_req_t   req = '0;
   logic                rsp_valid;
   logic                rsp_ready = 1'b0;
   lsu_pkg::lsu_rsp_t   rsp;
   logic                lsu_idle;

   logic [31:0]         vec_mem [VEC_COUNT*8];   // Eight columns per request
   logic [7:0]          ref_mem [`LSU_DCCM_DEPTH*4];  // Byte model of the DCCM
   logic [31:0]         lcg_state = SEED;
   int                  grp_checks [1:6];
   int                  grp_errs [1:6];
   int                  load_errs = 0;

   lsu_top dut_i (.*);

   bind lsu_top lsu_properties props_i (
      .clk(clk), .rst(rst), .req_ready(req_ready), .rsp_valid(rsp_valid),
      .rsp_ready(rsp_ready), .rsp(rsp), .dc1_valid(dc1_valid), .dc2_valid(dc2_valid),
      .dc3_valid(dc3_valid), .sb_full(sb_full), .mem_rden(mem_rden), .mem_wren(mem_wren)
   );

   always #(CLK_PERIOD/2) clk = ~clk;

   //******************************
   // Response back-pressure
   //******************************
   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   always @(posedge clk) begin
      lcg_state <= lcg_next(lcg_state);
      rsp_ready <= (lcg_state[31:16] % 3) != 0;   // Low about one cycle in three
   end

   //******************************
   // Reference model and checks
   //******************************
   function automatic logic [31:0] fault_code(input logic [31:0] size, input logic [31:0] ea);
      if ((size == 1 && ea[0]) || (size == 2 && ea[1:0] != 2'b00))
         return 32'd1;                              // Misaligned wins over range
      if (ea < `LSU_DCCM_BASE || ea >= `LSU_DCCM_BASE + `LSU_DCCM_DEPTH * 4)
         return 32'd2;                              // Outside the DCCM window
      return 32'd0;
   endfunction

   function automatic logic [31:0] model_load(input logic [31:0] size, input logic uns,
                                              input logic [31:0] ea);
      logic [9:0] a;
      a = 10'(ea - `LSU_DCCM_BASE);
      case (size)
         0: return uns ? {24'b0, ref_mem[a]} : {{24{ref_mem[a][7]}}, ref_mem[a]};
         1: return uns ? {16'b0, ref_mem[a+1], ref_mem[a]} :
                         {{16{ref_mem[a+1][7]}}, ref_mem[a+1], ref_mem[a]};
         default: return {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};
      endcase
   endfunction

   task automatic model_store(input logic [31:0] size, input logic [31:0] ea,
                              input logic [31:0] wdata);
      logic [9:0] a;
      int         n;
      a = 10'(ea - `LSU_DCCM_BASE);
      n = (size == 0) ? 1 : (size == 1) ? 2 : 4;
      for (int b = 0; b < n; b++)
         ref_mem[a + 10'(b)] = wdata[8*b +: 8];    // Little endian bytes
   endtask

   function automatic int group_of(input int i);
      if (i < G1_END) return 1;
      if (i < G2_END) return 2;
      if (i < G3_END) return 3;
      if (i < G4_END) return 4;
      return 5;                                     // Burst tail
   endfunction

   task automatic check_value(input int grp, input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      grp_checks[grp]++;
      if (got !== exp) begin
         grp_errs[grp]++;
         $display("** Error %s: got 0x%08h, expected 0x%08h", name, got, exp);
      end
   endtask

   task automatic report_group(input int g);
      string title;
      case (g)
         1: title = "word store and load";
         2: title = "byte and half extraction";
         3: title = "store buffer forwarding";
         4: title = "fault responses";
         5: title = "back-pressure and bursts";
         default: title = "idle flag";
      endcase
      $display("Group %0d %-26s %0d checks, %0d errors", g, title, grp_checks[g], grp_errs[g]);
   endtask

   // Vector line checked against the byte model at acceptance
   task automatic accept_vector(input int i);
      logic [31:0] ea;
      logic [31:0] err;
      logic [31:0] exp;
      int          row;
      row = 8 * i;
      ea  = vec_mem[row+3] + {{20{vec_mem[row+4][11]}}, vec_mem[row+4][11:0]};
      err = fault_code(vec_mem[row+1], ea);
      exp = '0;
      if (err == 0 && vec_mem[row][0] == 1'b0)
         exp = model_load(vec_mem[row+1], vec_mem[row+2][0], ea);
      else if (err == 0)
         model_store(vec_mem[row+1], ea, vec_mem[row+5]);   // Faulting stores skip
      check_value(group_of(i), $sformatf("vector %0d exp_err", i), vec_mem[row+7], err);
      check_value(group_of(i), $sformatf("vector %0d exp_data", i), vec_mem[row+6], exp);
   endtask

   //******************************
   // Driver and monitor
   //******************************
   task automatic drive_requests();
      lsu_pkg::lsu_req_t r;
      for (int i = 0; i < VEC_COUNT; i++) begin
         r.op          = lsu_pkg::lsu_op_e'(vec_mem[8*i][0]);
         r.size        = lsu_pkg::lsu_size_e'(vec_mem[8*i+1][1:0]);
         r.is_unsigned = vec_mem[8*i+2][0];
         r.base        = vec_mem[8*i+3];
         r.offset      = vec_mem[8*i+4][11:0];
         r.wdata       = vec_mem[8*i+5];
         req       <= r;
         req_valid <= 1'b1;
         @(posedge clk);
         while (!req_ready)
            @(posedge clk);                         // Held until accepted
         accept_vector(i);
      end
      req_valid <= 1'b0;
   endtask

   task automatic collect_responses();
      for (int j = 0; j < VEC_COUNT; j++) begin
         @(posedge clk);
         while (!(rsp_valid && rsp_ready))
            @(posedge clk);
         check_value(group_of(j), $sformatf("rsp.data[%0d]", j), rsp.data, vec_mem[8*j+6]);
         check_value(group_of(j), $sformatf("rsp.err[%0d]", j), {30'b0, rsp.err},
                     vec_mem[8*j+7]);
         if (group_of(j) != group_of(j + 1))
            report_group(group_of(j));              // Last response of the group
      end
   endtask

   //******************************
   // Main sequence
   //******************************
   initial begin : main
      int total;
      int checks;
      int prop_errs;
      $readmemh("sim/lsu_vectors.txt", vec_mem);
      if ($isunknown(vec_mem[VEC_COUNT*8-1])) begin
         $display("Vector file could not be read completely");
         load_errs++;
      end
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
      fork
         drive_requests();
         collect_responses();
      join
      report_group(5);

      while (!lsu_idle)
         @(posedge clk);                            // Watchdog bounds this wait
      repeat (IDLE_CYCLES) begin
         @(posedge clk);
         check_value(6, "lsu_idle", {31'b0, lsu_idle}, 32'd1);
         check_value(6, "rsp_valid", {31'b0, rsp_valid}, 32'd0);   // No stray response
      end
      report_group(6);

      total  = load_errs;
      checks = 0;
      for (int g = 1; g <= 6; g++) begin
         total  += grp_errs[g];
         checks += grp_checks[g];
      end
      prop_errs = dut_i.props_i.fail_count;
      total += prop_errs;
      $display("Summary: %0d checks, %0d errors, %0d assertion failures",
               checks, total - prop_errs, prop_errs);
      if (total == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

   initial begin : watchdog
      #(TIMEOUT_NS);
      $display("Timeout: the run did not complete within %0d ns", TIMEOUT_NS);
      $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu_addr_ctl.sv
hdl/lsu_stbuf.sv
hdl/lsu_dccm_ram.sv
hdl/lsu_load_align.sv
hdl/lsu_top.sv
sim/lsu_properties.sv
sim/lsu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the LSU testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f \
   --top-module lsu_tb -Mdir obj_dir -o lsu_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/lsu_sim +verilator+error+limit+100)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx 'All tests passed!'; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== sim/lsu_vectors.txt ====
// op size unsigned base offset store_data exp_data exp_err
// op 0 load 1 store, size 0 byte 1 half 2 word, err 0 none 1 misaligned 2 access
1 2 0 F0040100 010 11223344 00000000 0
1 2 0 F0040200 FF0 A5A55A5A 00000000 0
1 2 0 F0040000 020 CAFEF00D 00000000 0
0 2 0 F0040100 010 00000000 11223344 0
0 2 0 F0040200 FF0 00000000 A5A55A5A 0
0 0 0 F0040020 000 00000000 0000000D 0
0 0 1 F0040020 001 00000000 000000F0 0
0 0 0 F0040030 FF2 00000000 FFFFFFFE 0
0 0 1 F0040020 003 00000000 000000CA 0
0 1 0 F0040020 000 00000000 FFFFF00D 0
0 1 1 F0040020 002 00000000 0000CAFE 0
1 2 0 F0040040 000 01020304 00000000 0
1 0 0 F0040040 001 000000AA 00000000 0
1 1 0 F0040040 002 0000BBCC 00000000 0
0 2 0 F0040040 000 00000000 BBCCAA04 0
0 0 0 F0040040 003 00000000 FFFFFFBB 0
0 1 0 F0040020 001 00000000 00000000 1
1 2 0 F0040020 002 DEADBEEF 00000000 1
0 2 0 F0040000 FFC 00000000 00000000 2
1 2 0 F0040400 000 12345678 00000000 2
0 2 0 F0040020 000 00000000 CAFEF00D 0
1 2 0 F0040080 000 10000001 00000000 0
1 2 0 F0040080 004 20000002 00000000 0
1 2 0 F0040080 008 30000003 00000000 0
1 2 0 F0040090 FFC 40000004 00000000 0
1 2 0 F0040090 000 50000005 00000000 0
0 2 0 F0040080 004 00000000 20000002 0
0 2 0 F0040090 000 00000000 50000005 0
